//--- rtl/arm_isa_pkg.sv
package arm_isa_pkg;

    // ==================================================================
    // Field widths
    // ==================================================================

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int SHAMT_W   = 5;
    localparam int IMM12_W   = 12;
    localparam int IMM8_W    = 8;
    localparam int ROT_W     = 4;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [IMM12_W-1:0]   imm12_t;

    // Permanently undefined encoding, decodes as no instruction
    localparam word_t INSTR_RESET_WORD = 32'hE7F0_00F0;

    // LDR/STR I bit is inverted relative to data processing
    localparam logic LS_I_IMMEDIATE = 1'b0;

    // ==================================================================
    // Encodings
    // ==================================================================

    typedef enum logic [2:0] {
        ARM_INSTR_NONE,
        ARM_INSTR_DATAPROC_IMM,
        ARM_INSTR_DATAPROC_REG_IMM,
        ARM_INSTR_DATAPROC_REG_REG,
        ARM_INSTR_LOAD,
        ARM_INSTR_STORE
    } instr_type_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'b00,
        SHIFT_LSR = 2'b01,
        SHIFT_ASR = 2'b10,
        SHIFT_ROR = 2'b11
    } shift_t;

    // Opcode field values, carry and compare ops left out
    typedef enum logic [3:0] {
        ALU_OP_AND = 4'b0000,
        ALU_OP_EOR = 4'b0001,
        ALU_OP_SUB = 4'b0010,
        ALU_OP_RSB = 4'b0011,
        ALU_OP_ADD = 4'b0100,
        ALU_OP_ORR = 4'b1100,
        ALU_OP_MOV = 4'b1101,
        ALU_OP_BIC = 4'b1110,
        ALU_OP_MVN = 4'b1111
    } alu_op_t;

    typedef struct packed {
        instr_type_t          instr_type;
        reg_idx_t             rn;
        reg_idx_t             rd;
        reg_idx_t             rm;
        reg_idx_t             rs;
        alu_op_t              opcode;
        shift_t               shift_type;
        shamt_t               shift_amount;
        logic [IMM8_W-1:0]    imm8;
        logic [ROT_W-1:0]     rotate;
        imm12_t               imm12;
        logic                 i_bit;
        logic                 u_bit;
    } decoded_t;

endpackage

//--- rtl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    import arm_isa_pkg::*;

    // Stage counter width, longest instruction is two cycles
    localparam int STAGE_W = 2;

    // Register shift amounts use the low byte of rs
    localparam int REG_SHIFT_W = 8;

    // ==================================================================
    // Bus sources and writeback selects
    // ==================================================================

    typedef enum logic [1:0] {
        B_BUS_SRC_IMM,
        B_BUS_SRC_REG_RM,
        B_BUS_SRC_REG_RS
    } b_src_t;

    typedef enum logic {
        ADDR_SRC_PC,
        ADDR_SRC_ALU
    } addr_src_t;

    typedef enum logic [1:0] {
        ALU_WB_NONE,
        ALU_WB_REG_RD,
        ALU_WB_LOAD_RD
    } alu_wb_t;

    // ==================================================================
    // Control word
    // ==================================================================

    typedef struct packed {
        alu_wb_t    alu_writeback;
        logic       incrementer_writeback;
        addr_src_t  addr_bus_src;
        b_src_t     b_bus_source;
        imm12_t     b_bus_imm;
        shift_t     shift_type;
        shamt_t     shift_amount;
        logic       latch_shift_amt;
        logic       use_shift_latch;
        alu_op_t    alu_op;
        logic       mem_we;
    } control_t;

endpackage

//--- rtl/instr_decoder.sv
module instr_decoder
    import arm_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  word_t    fetch_word,
    output decoded_t decoded
);

    word_t ir;

    // Instruction register, loaded on every fetch cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= INSTR_RESET_WORD;
        end else if (enable) begin
            ir <= fetch_word;
        end
    end

    // Classify by bits 27..25, bit 4 and the L bit
    always_comb begin
        case (ir[27:25])
            3'b001:  decoded.instr_type = ARM_INSTR_DATAPROC_IMM;
            3'b000:  decoded.instr_type = ir[4] ? ARM_INSTR_DATAPROC_REG_REG
                                                : ARM_INSTR_DATAPROC_REG_IMM;
            3'b010:  decoded.instr_type = ir[20] ? ARM_INSTR_LOAD : ARM_INSTR_STORE;
            3'b011: begin
                // bit 4 set here is the undefined / media space
                if (ir[4]) begin
                    decoded.instr_type = ARM_INSTR_NONE;
                end else begin
                    decoded.instr_type = ir[20] ? ARM_INSTR_LOAD : ARM_INSTR_STORE;
                end
            end
            default: decoded.instr_type = ARM_INSTR_NONE;
        endcase
    end

    // Fields are pulled out regardless of class
    assign decoded.rn           = ir[19:16];
    assign decoded.rd           = ir[15:12];
    assign decoded.rs           = ir[11:8];
    assign decoded.rm           = ir[3:0];
    assign decoded.opcode       = alu_op_t'(ir[24:21]);
    assign decoded.shift_type   = shift_t'(ir[6:5]);
    assign decoded.shift_amount = ir[11:7];
    assign decoded.imm8         = ir[7:0];
    assign decoded.rotate       = ir[11:8];
    assign decoded.imm12        = ir[11:0];
    assign decoded.i_bit        = ir[25];
    assign decoded.u_bit        = ir[23];

endmodule

//--- rtl/control_unit.sv
module control_unit
    import arm_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  decoded_t decoded,
    output logic     decoder_enable,
    output control_t control_signals
);

    logic [STAGE_W-1:0] stage;

    // Back to zero on each fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (decoder_enable) begin
            stage <= '0;
        end else begin
            stage <= stage + 1'b1;
        end
    end

    always_comb begin
        control_signals = '0;
        decoder_enable  = 1'b1;

        case (decoded.instr_type)
            // ==========================================================
            // Single cycle forms, execute while fetching the next word
            // ==========================================================
            ARM_INSTR_DATAPROC_IMM: begin
                control_signals.alu_writeback         = ALU_WB_REG_RD;
                control_signals.incrementer_writeback = 1'b1;
                control_signals.b_bus_source          = B_BUS_SRC_IMM;
                control_signals.b_bus_imm             = imm12_t'(decoded.imm8);
                control_signals.shift_type            = SHIFT_ROR;
                control_signals.shift_amount          = {decoded.rotate, 1'b0};
                control_signals.alu_op                = decoded.opcode;
            end

            ARM_INSTR_DATAPROC_REG_IMM: begin
                control_signals.alu_writeback         = ALU_WB_REG_RD;
                control_signals.incrementer_writeback = 1'b1;
                control_signals.b_bus_source          = B_BUS_SRC_REG_RM;
                control_signals.shift_type            = decoded.shift_type;
                control_signals.shift_amount          = decoded.shift_amount;
                control_signals.alu_op                = decoded.opcode;
            end

            // ==========================================================
            // Register shift amount, rs is latched first
            // ==========================================================
            ARM_INSTR_DATAPROC_REG_REG: begin
                if (stage == 2'd0) begin
                    decoder_enable                  = 1'b0;
                    control_signals.b_bus_source    = B_BUS_SRC_REG_RS;
                    control_signals.latch_shift_amt = 1'b1;
                end else if (stage == 2'd1) begin
                    control_signals.alu_writeback         = ALU_WB_REG_RD;
                    control_signals.incrementer_writeback = 1'b1;
                    control_signals.b_bus_source          = B_BUS_SRC_REG_RM;
                    control_signals.use_shift_latch       = 1'b1;
                    control_signals.shift_type            = decoded.shift_type;
                    control_signals.alu_op                = decoded.opcode;
                end
            end

            // ==========================================================
            // Load and store, pre-indexed offset only
            // ==========================================================
            ARM_INSTR_LOAD, ARM_INSTR_STORE: begin
                if (stage == 2'd0) begin
                    decoder_enable               = 1'b0;
                    control_signals.addr_bus_src = ADDR_SRC_ALU;
                    control_signals.alu_op       = decoded.u_bit ? ALU_OP_ADD : ALU_OP_SUB;
                    control_signals.mem_we       = (decoded.instr_type == ARM_INSTR_STORE);
                    if (decoded.i_bit == LS_I_IMMEDIATE) begin
                        control_signals.b_bus_source = B_BUS_SRC_IMM;
                        control_signals.b_bus_imm    = decoded.imm12;
                        control_signals.shift_type   = SHIFT_LSL;
                    end else begin
                        control_signals.b_bus_source = B_BUS_SRC_REG_RM;
                        control_signals.shift_type   = decoded.shift_type;
                        control_signals.shift_amount = decoded.shift_amount;
                    end
                end else if (stage == 2'd1) begin
                    control_signals.incrementer_writeback = 1'b1;
                    if (decoded.instr_type == ARM_INSTR_LOAD) begin
                        control_signals.alu_writeback = ALU_WB_LOAD_RD;
                    end
                end
            end

            // Reset state and unsupported words just fetch
            default: begin
                control_signals.incrementer_writeback = 1'b1;
            end
        endcase
    end

endmodule

//--- rtl/barrel_shifter.sv
module barrel_shifter
    import arm_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  word_t  b_in,
    input  shift_t shift_type,
    input  shamt_t shift_amount,
    input  logic   latch_amt,
    input  logic   use_latch,
    output word_t  b_out
);

    logic [REG_SHIFT_W-1:0] amt_latch;
    logic                   amt_big;
    shamt_t                 amt;
    word_t                  sign_fill;

    always_ff @(posedge clk) begin
        if (rst) begin
            amt_latch <= '0;
        end else if (latch_amt) begin
            amt_latch <= b_in[REG_SHIFT_W-1:0];
        end
    end

    // Register amounts of 32 and up saturate
    assign amt_big   = use_latch && (amt_latch >= REG_SHIFT_W'(32));
    assign amt       = use_latch ? amt_latch[SHAMT_W-1:0] : shift_amount;
    assign sign_fill = {WORD_W{b_in[WORD_W-1]}};

    always_comb begin
        case (shift_type)
            SHIFT_LSL: b_out = amt_big ? '0 : b_in << amt;
            // Immediate #0 encodes a shift by 32
            SHIFT_LSR: begin
                if (amt_big || (!use_latch && amt == '0)) begin
                    b_out = '0;
                end else begin
                    b_out = b_in >> amt;
                end
            end
            SHIFT_ASR: begin
                if (amt_big || (!use_latch && amt == '0)) begin
                    b_out = sign_fill;
                end else begin
                    b_out = word_t'($signed(b_in) >>> amt);
                end
            end
            // No RRX, a zero rotate passes the value through
            default: b_out = (b_in >> amt) | (b_in << (6'd32 - {1'b0, amt}));
        endcase
    end

endmodule

//--- rtl/alu.sv
module alu
    import arm_isa_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    word_t sum;
    word_t diff;
    word_t rdiff;

    // Adders shared out of the case
    assign sum   = a + b;
    assign diff  = a - b;
    assign rdiff = b - a;

    always_comb begin
        case (op)
            ALU_OP_AND: begin
                result = a & b;
            end
            ALU_OP_EOR: begin
                result = a ^ b;
            end
            ALU_OP_SUB: begin
                result = diff;
            end
            ALU_OP_RSB: begin
                result = rdiff;
            end
            ALU_OP_ADD: begin
                result = sum;
            end
            ALU_OP_ORR: begin
                result = a | b;
            end
            // MOV and MVN only use the B operand
            ALU_OP_MOV: begin
                result = b;
            end
            ALU_OP_BIC: begin
                result = a & ~b;
            end
            ALU_OP_MVN: begin
                result = ~b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- rtl/register_bank.sv
module register_bank
    import core_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  rn_idx,
    input  logic [3:0]  rm_idx,
    input  logic [3:0]  rs_idx,
    input  logic [3:0]  rd_idx,
    input  b_src_t      b_source,
    input  alu_wb_t     wb_sel,
    input  logic [31:0] alu_result,
    input  logic [31:0] load_data,
    input  logic        incr_wb,
    output logic [31:0] rn_value,
    output logic [31:0] b_value,
    output logic [31:0] rd_value,
    output logic [31:0] pc
);

    logic [31:0] gpr [0:14];
    logic [31:0] pc_incr;
    logic [31:0] wb_data;
    logic [3:0]  b_idx;

    // Index 15 reads the program counter
    function automatic logic [31:0] read_reg(input logic [3:0] idx);
        if (idx == 4'd15) begin
            return pc;
        end
        return gpr[idx];
    endfunction

    assign pc_incr = pc + 32'd4;
    assign wb_data = (wb_sel == ALU_WB_LOAD_RD) ? load_data : alu_result;
    assign b_idx   = (b_source == B_BUS_SRC_REG_RS) ? rs_idx : rm_idx;

    // Read ports follow the register contents as well as the indices
    always_comb begin
        rn_value = read_reg(rn_idx);
        b_value  = read_reg(b_idx);
        rd_value = read_reg(rd_idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 15; i++) begin
                gpr[i] <= '0;
            end
            pc <= '0;
        end else begin
            if (incr_wb) begin
                pc <= pc_incr;
            end
            // Writes to r15 are dropped
            if (wb_sel != ALU_WB_NONE && rd_idx != 4'd15) begin
                gpr[rd_idx] <= wb_data;
            end
        end
    end

endmodule

//--- rtl/arm_core.sv
module arm_core
    import arm_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t mem_rdata,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we
);

    decoded_t decoded;
    control_t control_signals;
    logic     decoder_enable;

    word_t rn_value;
    word_t rm_or_rs_value;
    word_t rd_value;
    word_t pc;
    word_t b_bus;
    word_t b_shifted;
    word_t alu_result;
    word_t load_data;

    // ==================================================================
    // Bus multiplexers and load data latch
    // ==================================================================

    assign b_bus = (control_signals.b_bus_source == B_BUS_SRC_IMM)
                 ? word_t'(control_signals.b_bus_imm) : rm_or_rs_value;

    assign mem_addr  = (control_signals.addr_bus_src == ADDR_SRC_ALU) ? alu_result : pc;
    assign mem_wdata = rd_value;
    assign mem_we    = control_signals.mem_we;

    // Captured during the data read cycle of a load
    always_ff @(posedge clk) begin
        if (control_signals.addr_bus_src == ADDR_SRC_ALU && !control_signals.mem_we) begin
            load_data <= mem_rdata;
        end
    end

    // ==================================================================
    // Blocks
    // ==================================================================

    instr_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .enable     (decoder_enable),
        .fetch_word (mem_rdata),
        .decoded    (decoded)
    );

    control_unit u_control (
        .clk             (clk),
        .rst             (rst),
        .decoded         (decoded),
        .decoder_enable  (decoder_enable),
        .control_signals (control_signals)
    );

    register_bank u_regs (
        .clk        (clk),
        .rst        (rst),
        .rn_idx     (decoded.rn),
        .rm_idx     (decoded.rm),
        .rs_idx     (decoded.rs),
        .rd_idx     (decoded.rd),
        .b_source   (control_signals.b_bus_source),
        .wb_sel     (control_signals.alu_writeback),
        .alu_result (alu_result),
        .load_data  (load_data),
        .incr_wb    (control_signals.incrementer_writeback),
        .rn_value   (rn_value),
        .b_value    (rm_or_rs_value),
        .rd_value   (rd_value),
        .pc         (pc)
    );

    barrel_shifter u_shifter (
        .clk          (clk),
        .rst          (rst),
        .b_in         (b_bus),
        .shift_type   (control_signals.shift_type),
        .shift_amount (control_signals.shift_amount),
        .latch_amt    (control_signals.latch_shift_amt),
        .use_latch    (control_signals.use_shift_latch),
        .b_out        (b_shifted)
    );

    alu u_alu (
        .a      (rn_value),
        .b      (b_shifted),
        .op     (control_signals.alu_op),
        .result (alu_result)
    );

endmodule

//--- bench/arm_core_properties.sv
module arm_core_properties
    import arm_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     mem_we,
    input word_t    mem_addr,
    input logic     decoder_enable,
    input control_t control_signals
);
    timeunit 1ns;
    timeprecision 1ps;

    // A store is always followed by a fetch cycle
    no_back_to_back_we: assert property (
        @(posedge clk) disable iff (rst) mem_we |=> !mem_we
    ) else $error("mem_we high in two cycles in a row");

    we_low_after_reset: assert property (
        @(posedge clk) rst |=> !mem_we
    ) else $error("mem_we high right after reset");

    fetch_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (control_signals.addr_bus_src == ADDR_SRC_PC) |-> (mem_addr[1:0] == 2'b00)
    ) else $error("Fetch address not word aligned");

    // Loading the instruction register only on a pure fetch
    enable_only_on_fetch: assert property (
        @(posedge clk) disable iff (rst)
        decoder_enable |-> (control_signals.addr_bus_src == ADDR_SRC_PC && !mem_we)
    ) else $error("Decoder enabled outside a fetch cycle");

endmodule

bind arm_core arm_core_properties props (
    .clk             (clk),
    .rst             (rst),
    .mem_we          (mem_we),
    .mem_addr        (mem_addr),
    .decoder_enable  (decoder_enable),
    .control_signals (control_signals)
);

//--- bench/arm_core_tb.sv
module arm_core_tb
    import arm_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic  clk;
    logic  rst;
    word_t mem_rdata;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_we;

    // Program in words 0..1023, data in words 1024..2047
    word_t mem [0:2047];
    word_t ref_mem [0:2047];
    word_t ref_regs [0:14];
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    logic [31:0] lfsr_state;
    word_t       end_addr;
    int          store_idx;
    int          limit_cycles;
    logic        gen_done;
    logic        done;

    arm_core dut (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    always #2 clk = ~clk;

    assign mem_rdata = mem[mem_addr[12:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr[12:2]] <= mem_wdata;
        end
    end

    // ==================================================================
    // Random numbers and instruction encoding
    // ==================================================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'hB4BC_D35C : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic int pick(input int n);
        return int'(rand_bits(8)) % n;
    endfunction

    function automatic alu_op_t pick_op();
        alu_op_t ops [9];
        ops = '{ALU_OP_MOV, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_ORR,
                ALU_OP_EOR, ALU_OP_BIC, ALU_OP_MVN, ALU_OP_RSB};
        return ops[pick(9)];
    endfunction

    function automatic word_t enc_dp_imm(input alu_op_t op, input reg_idx_t rn,
                                         input reg_idx_t rd, input logic [3:0] rot,
                                         input logic [7:0] imm8);
        return {4'hE, 3'b001, op, 1'b0, rn, rd, rot, imm8};
    endfunction

    function automatic word_t enc_dp_shift_imm(input alu_op_t op, input reg_idx_t rn,
                                               input reg_idx_t rd, input shamt_t amt,
                                               input shift_t sh, input reg_idx_t rm);
        return {4'hE, 3'b000, op, 1'b0, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    function automatic word_t enc_dp_shift_reg(input alu_op_t op, input reg_idx_t rn,
                                               input reg_idx_t rd, input reg_idx_t rs,
                                               input shift_t sh, input reg_idx_t rm);
        return {4'hE, 3'b000, op, 1'b0, rn, rd, rs, 1'b0, sh, 1'b1, rm};
    endfunction

    function automatic word_t enc_mem_imm(input logic load, input logic u, input reg_idx_t rn,
                                          input reg_idx_t rd, input imm12_t off);
        return {4'hE, 2'b01, 1'b0, 1'b1, u, 2'b00, load, rn, rd, off};
    endfunction

    function automatic word_t enc_mem_reg(input logic load, input logic u, input reg_idx_t rn,
                                          input reg_idx_t rd, input shamt_t amt,
                                          input shift_t sh, input reg_idx_t rm);
        return {4'hE, 2'b01, 1'b1, 1'b1, u, 2'b00, load, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    // Store r0..r11 above the r12 base, then one store relative to pc
    task automatic dump_regs();
        for (int i = 0; i < 12; i++) begin
            prog.push_back(enc_mem_imm(1'b0, 1'b1, 4'd12, reg_idx_t'(i), imm12_t'(4 * i)));
        end
        prog.push_back(enc_mem_imm(1'b0, 1'b1, 4'd15, 4'd0, 12'hFFC));
    endtask

    // Offsets stay inside the data region around the 0x1800 base
    task automatic emit_mem(input logic load, input reg_idx_t rd);
        logic u;
        u = 1'(rand_bits(1));
        if (rand_bits(1) != 0) begin
            prog.push_back(enc_dp_imm(ALU_OP_MOV, 4'd0, 4'd11, 4'd0, 8'(rand_bits(8))));
            prog.push_back(enc_mem_reg(load, u, 4'd12, rd, 5'd2, SHIFT_LSL, 4'd11));
        end else begin
            prog.push_back(enc_mem_imm(load, u, 4'd12, rd, imm12_t'(rand_bits(9) << 2)));
        end
    endtask

    // ==================================================================
    // Reference model of the instruction set
    // ==================================================================

    function automatic word_t ror32(input word_t v, input int n);
        int m;
        m = n % 32;
        if (m == 0) begin
            return v;
        end
        return (v >> m) | (v << (32 - m));
    endfunction

    function automatic word_t shift_ref(input word_t v, input logic [1:0] sh, input int amt,
                                        input logic by_reg);
        word_t fill;
        fill = v[31] ? 32'hFFFF_FFFF : 32'h0;
        if (by_reg && amt == 0) begin
            return v;
        end
        case (sh)
            2'b00: return (amt >= 32) ? 32'h0 : v << amt;
            2'b01: return (amt >= 32 || amt == 0) ? 32'h0 : v >> amt;
            2'b10: return (amt >= 32 || amt == 0) ? fill : word_t'($signed(v) >>> amt);
            default: return ror32(v, amt);
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [3:0] op, input word_t a, input word_t b);
        case (op)
            4'b0000: return a & b;
            4'b0001: return a ^ b;
            4'b0010: return a - b;
            4'b0011: return b - a;
            4'b0100: return a + b;
            4'b1100: return a | b;
            4'b1101: return b;
            4'b1110: return a & ~b;
            4'b1111: return ~b;
            default: return 32'h0;
        endcase
    endfunction

    // r15 reads as the address after the instruction, pc moved on at fetch
    function automatic word_t read_ref(input logic [3:0] idx, input word_t pcv);
        return (idx == 4'd15) ? pcv : ref_regs[idx];
    endfunction

    function automatic void write_ref(input logic [3:0] idx, input word_t v);
        if (idx != 4'd15) begin
            ref_regs[idx] = v;
        end
    endfunction

    function automatic void run_reference();
        word_t w;
        word_t a;
        word_t b;
        word_t rsv;
        word_t addr;
        word_t pcv;
        for (int i = 0; i < 15; i++) begin
            ref_regs[i] = '0;
        end
        for (int k = 0; k < prog.size(); k++) begin
            w   = prog[k];
            pcv = word_t'(4 * k + 4);
            a   = read_ref(w[19:16], pcv);
            case (w[27:25])
                3'b001: begin
                    b = ror32({24'h0, w[7:0]}, 2 * int'(w[11:8]));
                    write_ref(w[15:12], alu_ref(w[24:21], a, b));
                end
                3'b000: begin
                    if (w[4]) begin
                        rsv = read_ref(w[11:8], pcv);
                        b = shift_ref(read_ref(w[3:0], pcv), w[6:5], int'(rsv[7:0]), 1'b1);
                    end else begin
                        b = shift_ref(read_ref(w[3:0], pcv), w[6:5], int'(w[11:7]), 1'b0);
                    end
                    write_ref(w[15:12], alu_ref(w[24:21], a, b));
                end
                default: begin
                    if (w[25]) begin
                        b = shift_ref(read_ref(w[3:0], pcv), w[6:5], int'(w[11:7]), 1'b0);
                    end else begin
                        b = {20'h0, w[11:0]};
                    end
                    addr = w[23] ? a + b : a - b;
                    if (w[20]) begin
                        write_ref(w[15:12], ref_mem[addr[12:2]]);
                    end else begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(read_ref(w[15:12], pcv));
                        ref_mem[addr[12:2]] = read_ref(w[15:12], pcv);
                    end
                end
            endcase
        end
    endfunction

    // ==================================================================
    // Checks
    // ==================================================================

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_addr(input word_t expected);
        if (mem_addr !== expected) begin
            $display("FAILED at %0t: mem_addr expected %h, got %h", $time, expected, mem_addr);
            abort_run();
        end
    endtask

    task automatic check_data(input word_t expected);
        if (mem_wdata !== expected) begin
            $display("FAILED at %0t: mem_wdata expected %h, got %h", $time, expected,
                     mem_wdata);
            abort_run();
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (mem_we) begin
            if (store_idx >= exp_addr.size()) begin
                $display("The core wrote more often than the program stores, at %0t", $time);
                abort_run();
            end else begin
                check_addr(exp_addr[store_idx]);
                check_data(exp_data[store_idx]);
                store_idx++;
            end
        end else if (gen_done && mem_addr == end_addr) begin
            done = 1'b1;
        end
    end

    initial begin
        wait (gen_done);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the core did not reach the end of the program");
        abort_run();
    end

    // ==================================================================
    // Program generation and main sequence
    // ==================================================================

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        gen_done   = 1'b0;
        done       = 1'b0;
        store_idx  = 0;
        end_addr   = 32'hFFFF_FFFF;
        lfsr_state = 32'd49;

        // r12 = 0x18 ROR 24 = 0x1800, the data base
        prog.push_back(enc_dp_imm(ALU_OP_MOV, 4'd0, 4'd12, 4'd12, 8'h18));

        // Rotated immediates
        for (int i = 0; i < 30; i++) begin
            prog.push_back(enc_dp_imm(pick_op(), reg_idx_t'(pick(13)), reg_idx_t'(pick(12)),
                                      4'(rand_bits(4)), 8'(rand_bits(8))));
        end
        dump_regs();

        // Register shifted by an immediate, every fifth amount is 0 so each type sees it
        for (int i = 0; i < 32; i++) begin
            prog.push_back(enc_dp_shift_imm(pick_op(), reg_idx_t'(pick(13)),
                                            reg_idx_t'(pick(12)),
                                            (i % 5 == 0) ? 5'd0 : 5'(rand_bits(5)),
                                            shift_t'(i % 4), reg_idx_t'(pick(13))));
        end
        dump_regs();

        // Register shifted by r11, amounts 0..40, then amount 0 for the other shift types
        for (int n = 0; n < 44; n++) begin
            prog.push_back(enc_dp_imm(ALU_OP_MOV, 4'd0, 4'd11, 4'd0,
                                      (n <= 40) ? 8'(n) : 8'd0));
            prog.push_back(enc_dp_shift_reg(pick_op(), reg_idx_t'(pick(11)),
                                            reg_idx_t'(pick(11)), 4'd11,
                                            shift_t'(n % 4), reg_idx_t'(pick(11))));
        end
        dump_regs();

        // Load a preloaded word, store it elsewhere
        for (int i = 0; i < 24; i++) begin
            emit_mem(1'b1, reg_idx_t'(i % 11));
            emit_mem(1'b0, reg_idx_t'(i % 11));
        end
        dump_regs();

        for (int k = 0; k < 2048; k++) begin
            if (k < prog.size()) begin
                mem[k] = prog[k];
            end else if (k < 1024) begin
                mem[k] = INSTR_RESET_WORD;
            end else begin
                mem[k] = rand_bits(32);
            end
            ref_mem[k] = mem[k];
        end

        run_reference();
        end_addr     = word_t'(4 * prog.size());
        limit_cycles = 2 * prog.size() + 5 + 50;
        gen_done     = 1'b1;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        wait (done);
        @(negedge clk);
        if (store_idx != exp_addr.size()) begin
            $display("Store count wrong: expected %0d, saw %0d", exp_addr.size(), store_idx);
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- list.f
rtl/arm_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/control_unit.sv
rtl/barrel_shifter.sv
rtl/alu.sv
rtl/register_bank.sv
rtl/arm_core.sv
bench/arm_core_properties.sv
bench/arm_core_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "test   build with Verilator and run the testbench"
	@echo "clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module arm_core_tb -Mdir obj_dir
	out=$$(./obj_dir/Varm_core_tb); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
